// File: rtl/median_pkg.sv
`default_nettype none

package median_pkg;

  // window geometry, fixed at 7x7 since the pruning pattern depends on it
  localparam int unsigned WIN_N    = 7;
  localparam int unsigned WIN_SIZE = WIN_N * WIN_N;

  // candidates left after pruning the sorted grid
  localparam int unsigned CAND_N   = 25;

  // zero-based rank of the median among the candidates
  localparam int unsigned MED_RANK = 12;

  // default pixel width, overridable from the top level
  localparam int unsigned PIX_W_DEF = 8;

  // count of candidates, 0 to 24
  typedef logic [4:0] cand_cnt_t;

  // row or rank index inside the window, 0 to 6
  typedef logic [2:0] win_idx_t;

endpackage

`default_nettype wire

// File: rtl/sort7_net.sv
`timescale 1ns/1ps
`default_nettype none

module sort7_net #(
  parameter int unsigned PIX_W = 8
) (
  input  logic [median_pkg::WIN_N*PIX_W-1:0] in_i,
  output logic [median_pkg::WIN_N*PIX_W-1:0] sorted_o
);

  import median_pkg::*;

  typedef logic [PIX_W-1:0] pix_t;

  // 16 compare-exchange elements in 6 layers
  localparam int unsigned CE_N = 16;

  localparam int unsigned CE_LO [CE_N] = '{
    0, 2, 4,
    0, 1, 3,
    0, 2, 3,
    1, 4,
    2, 4,
    1, 3, 5
  };

  localparam int unsigned CE_HI [CE_N] = '{
    6, 3, 5,
    2, 4, 6,
    1, 5, 4,
    2, 6,
    3, 5,
    2, 4, 6
  };

  pix_t v [WIN_N];
  pix_t lo;
  pix_t hi;

  always_comb begin
    for (int unsigned i = 0; i < WIN_N; i++) begin
      v[i] = in_i[i*PIX_W +: PIX_W];
    end

    // each element leaves the smaller value on the lower lane
    for (int unsigned c = 0; c < CE_N; c++) begin
      lo = v[CE_LO[c]];
      hi = v[CE_HI[c]];
      if (lo > hi) begin
        v[CE_LO[c]] = hi;
        v[CE_HI[c]] = lo;
      end
    end

    // lane 0 holds the minimum
    for (int unsigned i = 0; i < WIN_N; i++) begin
      sorted_o[i*PIX_W +: PIX_W] = v[i];
    end
  end

endmodule

`default_nettype wire

// File: rtl/row_sort_stage.sv
`timescale 1ns/1ps
`default_nettype none

module row_sort_stage #(
  parameter int unsigned PIX_W = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  done_i,
  input  logic [median_pkg::WIN_SIZE*PIX_W-1:0] win_i,
  output logic [median_pkg::WIN_SIZE*PIX_W-1:0] grid_o,
  output logic                                  vld_o
);

  import median_pkg::*;

  localparam int unsigned ROW_W = WIN_N * PIX_W;

  logic [WIN_SIZE*PIX_W-1:0] win_q;
  logic                      vld_q;
  logic [WIN_SIZE*PIX_W-1:0] row_sorted;

  // input capture
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      win_q <= '0;
      vld_q <= 1'b0;
    end else begin
      win_q <= win_i;
      vld_q <= done_i;
    end
  end

  // row r of the window lands on grid row r, with k the rank in the row
  for (genvar r = 0; r < WIN_N; r++) begin : g_row
    sort7_net #(
      .PIX_W(PIX_W)
    ) u_sort (
      .in_i    (win_q[r*ROW_W +: ROW_W]),
      .sorted_o(row_sorted[r*ROW_W +: ROW_W])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grid_o <= '0;
      vld_o  <= 1'b0;
    end else begin
      grid_o <= row_sorted;
      vld_o  <= vld_q;
    end
  end

endmodule

`default_nettype wire

// File: rtl/col_sort_stage.sv
`timescale 1ns/1ps
`default_nettype none

module col_sort_stage #(
  parameter int unsigned PIX_W = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  vld_i,
  input  logic [median_pkg::WIN_SIZE*PIX_W-1:0] grid_i,
  output logic [median_pkg::WIN_SIZE*PIX_W-1:0] grid_o,
  output logic                                  vld_o
);

  import median_pkg::*;

  logic [WIN_N*PIX_W-1:0]    col_in  [WIN_N];
  logic [WIN_N*PIX_W-1:0]    col_out [WIN_N];
  logic [WIN_SIZE*PIX_W-1:0] col_sorted;

  // flat grid position of (r, k)
  function automatic int unsigned grid_pos(input win_idx_t r, input win_idx_t k);
    return int'(r) * WIN_N + int'(k);
  endfunction

  for (genvar k = 0; k < WIN_N; k++) begin : g_col
    // gather the k-th ranked value of every row
    for (genvar r = 0; r < WIN_N; r++) begin : g_lane
      assign col_in[k][r*PIX_W +: PIX_W] =
        grid_i[grid_pos(win_idx_t'(r), win_idx_t'(k))*PIX_W +: PIX_W];
      assign col_sorted[grid_pos(win_idx_t'(r), win_idx_t'(k))*PIX_W +: PIX_W] =
        col_out[k][r*PIX_W +: PIX_W];
    end

    sort7_net #(
      .PIX_W(PIX_W)
    ) u_sort (
      .in_i    (col_in[k]),
      .sorted_o(col_out[k])
    );
  end

  // r now counts the rank inside the column
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      grid_o <= '0;
      vld_o  <= 1'b0;
    end else begin
      grid_o <= col_sorted;
      vld_o  <= vld_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/cand_select.sv
`timescale 1ns/1ps
`default_nettype none

module cand_select #(
  parameter int unsigned PIX_W = 8
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  vld_i,
  input  logic [median_pkg::WIN_SIZE*PIX_W-1:0] grid_i,
  output logic [median_pkg::CAND_N*PIX_W-1:0]   cand_o,
  output logic                                  vld_o
);

  import median_pkg::*;

  typedef logic [PIX_W-1:0] pix_t;

  // slots filled from the diagonal triples instead of the table
  localparam int unsigned UL_SLOT = 5;
  localparam int unsigned LR_SLOT = 19;

  // candidate coordinates (k, r) in output order
  localparam win_idx_t CAND_K [CAND_N] = '{
    3'd5, 3'd6, 3'd4, 3'd5, 3'd6, 3'd3, 3'd3, 3'd4, 3'd5, 3'd6,
    3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd0, 3'd1, 3'd2, 3'd3, 3'd3,
    3'd0, 3'd1, 3'd2, 3'd0, 3'd1
  };
  localparam win_idx_t CAND_R [CAND_N] = '{
    3'd0, 3'd0, 3'd1, 3'd1, 3'd1, 3'd1, 3'd2, 3'd2, 3'd2, 3'd2,
    3'd3, 3'd3, 3'd3, 3'd3, 3'd3, 3'd4, 3'd4, 3'd4, 3'd4, 3'd5,
    3'd5, 3'd5, 3'd5, 3'd6, 3'd6
  };

  pix_t ul_max;
  pix_t lr_min;
  logic [CAND_N*PIX_W-1:0] cand_d;

  function automatic pix_t pix_at(input win_idx_t k, input win_idx_t r);
    return grid_i[(int'(r) * WIN_N + int'(k))*PIX_W +: PIX_W];
  endfunction

  function automatic pix_t max3(input pix_t a, input pix_t b, input pix_t c);
    pix_t m;
    m = (a > b) ? a : b;
    return (m > c) ? m : c;
  endfunction

  function automatic pix_t min3(input pix_t a, input pix_t b, input pix_t c);
    pix_t m;
    m = (a < b) ? a : b;
    return (m < c) ? m : c;
  endfunction

  // only the max of the upper and the min of the lower diagonal can be the median
  assign ul_max = max3(pix_at(3'd2, 3'd2), pix_at(3'd3, 3'd1), pix_at(3'd4, 3'd0));
  assign lr_min = min3(pix_at(3'd2, 3'd6), pix_at(3'd3, 3'd5), pix_at(3'd4, 3'd4));

  always_comb begin
    for (int unsigned i = 0; i < CAND_N; i++) begin
      if (i == UL_SLOT) begin
        cand_d[i*PIX_W +: PIX_W] = ul_max;
      end else if (i == LR_SLOT) begin
        cand_d[i*PIX_W +: PIX_W] = lr_min;
      end else begin
        cand_d[i*PIX_W +: PIX_W] = pix_at(CAND_K[i], CAND_R[i]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cand_o <= '0;
      vld_o  <= 1'b0;
    end else begin
      cand_o <= cand_d;
      vld_o  <= vld_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/rank_select25.sv
`timescale 1ns/1ps
`default_nettype none

module rank_select25 #(
  parameter int unsigned PIX_W = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  input  logic                                vld_i,
  input  logic [median_pkg::CAND_N*PIX_W-1:0] cand_i,
  output logic [PIX_W-1:0]                    median_o,
  output logic                                vld_o
);

  import median_pkg::*;

  typedef logic [PIX_W-1:0] pix_t;

  pix_t      cand   [CAND_N];
  cand_cnt_t lt_cnt [CAND_N];
  cand_cnt_t eq_cnt [CAND_N];
  logic      hit    [CAND_N];
  pix_t      sel;

  always_comb begin
    for (int unsigned i = 0; i < CAND_N; i++) begin
      cand[i] = cand_i[i*PIX_W +: PIX_W];
    end
  end

  // pairwise compare, eq_cnt counts the other candidates only
  always_comb begin
    for (int unsigned i = 0; i < CAND_N; i++) begin
      lt_cnt[i] = '0;
      eq_cnt[i] = '0;
      for (int unsigned j = 0; j < CAND_N; j++) begin
        if (j != i) begin
          lt_cnt[i] = lt_cnt[i] + cand_cnt_t'(cand[j] < cand[i]);
          eq_cnt[i] = eq_cnt[i] + cand_cnt_t'(cand[j] == cand[i]);
        end
      end
    end
  end

  // candidate i spans ranks lt_cnt .. lt_cnt + eq_cnt
  always_comb begin
    for (int unsigned i = 0; i < CAND_N; i++) begin
      hit[i] = (int'(lt_cnt[i]) <= MED_RANK) &&
               (int'(lt_cnt[i]) + int'(eq_cnt[i]) + 1 > MED_RANK);
    end
  end

  // all hits carry the same value, so any of them will do
  always_comb begin
    sel = '0;
    for (int unsigned i = 0; i < CAND_N; i++) begin
      if (hit[i]) begin
        sel = cand[i];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      median_o <= '0;
      vld_o    <= 1'b0;
    end else begin
      median_o <= sel;
      vld_o    <= vld_i;
    end
  end

endmodule

`default_nettype wire

// File: rtl/median7x7_top.sv
`timescale 1ns/1ps
`default_nettype none

module median7x7_top #(
  parameter int unsigned PIX_W = median_pkg::PIX_W_DEF
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  done_i,
  input  logic [median_pkg::WIN_SIZE*PIX_W-1:0] win_i,
  output logic [PIX_W-1:0]                      median_o,
  output logic                                  done_o
);

  import median_pkg::*;

  logic [WIN_SIZE*PIX_W-1:0] row_grid;
  logic [WIN_SIZE*PIX_W-1:0] col_grid;
  logic [CAND_N*PIX_W-1:0]   cand;
  logic                      row_vld;
  logic                      col_vld;
  logic                      cand_vld;

  // two cycles: capture, then sort rows
  row_sort_stage #(
    .PIX_W(PIX_W)
  ) u_row (
    .clk   (clk),
    .rst_n (rst_n),
    .done_i(done_i),
    .win_i (win_i),
    .grid_o(row_grid),
    .vld_o (row_vld)
  );

  col_sort_stage #(
    .PIX_W(PIX_W)
  ) u_col (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (row_vld),
    .grid_i(row_grid),
    .grid_o(col_grid),
    .vld_o (col_vld)
  );

  cand_select #(
    .PIX_W(PIX_W)
  ) u_cand (
    .clk   (clk),
    .rst_n (rst_n),
    .vld_i (col_vld),
    .grid_i(col_grid),
    .cand_o(cand),
    .vld_o (cand_vld)
  );

  rank_select25 #(
    .PIX_W(PIX_W)
  ) u_rank (
    .clk     (clk),
    .rst_n   (rst_n),
    .vld_i   (cand_vld),
    .cand_i  (cand),
    .median_o(median_o),
    .vld_o   (done_o)
  );

endmodule

`default_nettype wire

// File: verification/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_n_o
);

  logic por_n;

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // power-on reset for 5 cycles, released between edges
  initial begin
    por_n = 1'b0;
    repeat (5) @(posedge clk_o);
    #3;
    por_n = 1'b1;
  end

  assign rst_n_o = por_n & ~rst_req_i;

endmodule

`default_nettype wire

// File: verification/median7x7_chk.sv
`timescale 1ns/1ps
`default_nettype none

module median7x7_chk #(
  parameter int unsigned PIX_W = 8
) (
  input logic                                  clk,
  input logic                                  rst_n,
  input logic                                  done_i,
  input logic [median_pkg::WIN_SIZE*PIX_W-1:0] win_i,
  input logic [PIX_W-1:0]                      dut_median_i,
  input logic                                  dut_done_i
);

  import median_pkg::*;

  localparam int unsigned LAT = 5;

  logic [PIX_W-1:0] win_lo;
  logic [PIX_W-1:0] win_hi;
  logic [PIX_W-1:0] lo_sh [LAT];
  logic [PIX_W-1:0] hi_sh [LAT];
  logic [LAT-1:0]   done_sh;
  logic [2:0]       since_rst;
  int               lat_errs = 0;
  int               rst_errs = 0;
  int               range_errs = 0;
  int               err_cnt;

  assign err_cnt = lat_errs + rst_errs + range_errs;

  // bounds of the window on the input
  always_comb begin
    win_lo = '1;
    win_hi = '0;
    for (int unsigned i = 0; i < WIN_SIZE; i++) begin
      if (win_i[i*PIX_W +: PIX_W] < win_lo) begin
        win_lo = win_i[i*PIX_W +: PIX_W];
      end
      if (win_i[i*PIX_W +: PIX_W] > win_hi) begin
        win_hi = win_i[i*PIX_W +: PIX_W];
      end
    end
  end

  // strobe and bounds delayed to line up with done_o
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done_sh   <= '0;
      since_rst <= '0;
      for (int unsigned i = 0; i < LAT; i++) begin
        lo_sh[i] <= '0;
        hi_sh[i] <= '0;
      end
    end else begin
      done_sh  <= {done_sh[LAT-2:0], done_i};
      lo_sh[0] <= win_lo;
      hi_sh[0] <= win_hi;
      for (int unsigned i = 1; i < LAT; i++) begin
        lo_sh[i] <= lo_sh[i-1];
        hi_sh[i] <= hi_sh[i-1];
      end
      if (since_rst < 3'(LAT)) begin
        since_rst <= since_rst + 3'd1;
      end
    end
  end

  assert property (@(posedge clk) dut_done_i == done_sh[LAT-1])
    else begin
      lat_errs++;
      $error("done_o does not follow done_i by exactly five cycles");
    end

  // nothing may leave the pipe during reset or just after it
  assert property (@(posedge clk) (since_rst < 3'(LAT)) |-> !dut_done_i)
    else begin
      rst_errs++;
      $error("done_o went high during reset or within five cycles of its release");
    end

  assert property (@(posedge clk) dut_done_i |->
                   (dut_median_i >= lo_sh[LAT-1] && dut_median_i <= hi_sh[LAT-1]))
    else begin
      range_errs++;
      $error("median_o lies outside the range of its window");
    end

endmodule

bind median7x7_top median7x7_chk #(
  .PIX_W(PIX_W)
) u_chk (
  .clk         (clk),
  .rst_n       (rst_n),
  .done_i      (done_i),
  .win_i       (win_i),
  .dut_median_i(median_o),
  .dut_done_i  (done_o)
);

`default_nettype wire

// File: verification/median7x7_tb.sv
`timescale 1ns/1ps
`default_nettype none

module median7x7_tb;

  import median_pkg::*;

  localparam int unsigned PIX_W   = 8;
  localparam int unsigned WIN_W   = WIN_SIZE * PIX_W;
  localparam int unsigned RAND_N  = 200;
  localparam int unsigned MAX_GAP = 7;
  localparam int unsigned B2B_N   = 50;
  localparam int unsigned DIR_CYC = 40;
  localparam int unsigned RST_CYC = 30;
  // reset, directed, random with gaps, back-to-back, mid-run reset
  localparam int unsigned STIM_CYC =
    5 + DIR_CYC + RAND_N * (MAX_GAP + 1) + B2B_N + RST_CYC;
  localparam int unsigned CYC_LIMIT = STIM_CYC + 5 + 50;

  typedef logic [PIX_W-1:0] pix_t;
  typedef logic [WIN_W-1:0] win_t;

  logic        clk;
  logic        rst_n;
  logic        rst_req;
  logic        done_i;
  logic        done_o;
  win_t        win_i;
  pix_t        median_o;
  pix_t        exp_q [$];
  int unsigned cyc = 0;
  int          val_errs = 0;
  int          strobe_errs = 0;

  clk_gen u_clk (
    .rst_req_i(rst_req),
    .clk_o    (clk),
    .rst_n_o  (rst_n)
  );

  median7x7_top #(
    .PIX_W(PIX_W)
  ) dut0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .done_i  (done_i),
    .win_i   (win_i),
    .median_o(median_o),
    .done_o  (done_o)
  );

  // 25th smallest of the window by a full insertion sort
  function automatic pix_t full_sort_median(input win_t w);
    pix_t px [WIN_SIZE];
    pix_t t;
    int   j;
    for (int i = 0; i < int'(WIN_SIZE); i++) begin
      px[i] = w[i*PIX_W +: PIX_W];
    end
    for (int i = 1; i < int'(WIN_SIZE); i++) begin
      t = px[i];
      j = i;
      while (j > 0 && px[j-1] > t) begin
        px[j] = px[j-1];
        j--;
      end
      px[j] = t;
    end
    return px[WIN_SIZE/2];
  endfunction

  function automatic win_t rand_window();
    win_t w;
    for (int i = 0; i < int'(WIN_SIZE); i++) begin
      w[i*PIX_W +: PIX_W] = pix_t'($urandom);
    end
    return w;
  endfunction

  function automatic win_t two_value_window(input pix_t a, input pix_t b);
    win_t w;
    for (int i = 0; i < int'(WIN_SIZE); i++) begin
      w[i*PIX_W +: PIX_W] = ($urandom_range(0, 1) != 0) ? a : b;
    end
    return w;
  endfunction

  // ascending or descending in row-major order
  function automatic win_t ramp_window(input logic down);
    win_t w;
    for (int i = 0; i < int'(WIN_SIZE); i++) begin
      w[i*PIX_W +: PIX_W] = pix_t'(down ? 240 - 5 * i : 5 * i);
    end
    return w;
  endfunction

  task automatic send_window(input win_t w);
    win_i  = w;
    done_i = 1'b1;
    exp_q.push_back(full_sort_median(w));
    @(posedge clk);
    #1;
  endtask

  task automatic idle(input int unsigned n);
    done_i = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // outputs read mid-cycle, away from the clock edge
  always @(negedge clk) begin
    if (done_o) begin
      if (exp_q.size() == 0) begin
        strobe_errs++;
        $display("done_o high with no window pending at cycle %0d", cyc);
      end else begin
        assert (median_o == exp_q[0])
          else begin
            val_errs++;
            $display("ERR median_o got %h exp %h", median_o, exp_q[0]);
          end
        void'(exp_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= CYC_LIMIT) begin
      $display("timeout after %0d cycles with %0d medians missing", cyc, exp_q.size());
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h5f5f));
    rst_req = 1'b0;
    done_i  = 1'b0;
    win_i   = '0;
    wait (rst_n === 1'b1);
    @(posedge clk);
    #1;

    // uniform windows, both extremes
    send_window('0);
    idle(1);
    send_window('1);
    idle(6);
    send_window({WIN_SIZE{8'h5a}});
    send_window(two_value_window(8'h00, 8'hff));
    send_window(two_value_window(8'h40, 8'h41));
    send_window(two_value_window(8'h10, 8'h11));
    idle(2);
    send_window(ramp_window(1'b0));
    send_window(ramp_window(1'b1));
    idle(6);

    // random windows, isolated and with short gaps
    for (int n = 0; n < int'(RAND_N); n++) begin
      send_window(rand_window());
      idle($urandom_range(0, MAX_GAP));
    end

    for (int n = 0; n < int'(B2B_N); n++) begin
      send_window(rand_window());
    end
    idle(6);

    // reset with three windows still in flight
    send_window(rand_window());
    send_window(rand_window());
    send_window(rand_window());
    rst_req = 1'b1;
    exp_q.delete();
    idle(3);
    rst_req = 1'b0;
    idle(2);
    send_window(rand_window());
    idle(1);

    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    // room for any stray strobe
    idle(8);

    $display("errors: median %0d, strobe %0d, checker %0d",
             val_errs, strobe_errs, dut0.u_chk.err_cnt);
    if (val_errs == 0 && strobe_errs == 0 && dut0.u_chk.err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
rtl/median_pkg.sv
rtl/sort7_net.sv
rtl/row_sort_stage.sv
rtl/col_sort_stage.sv
rtl/cand_select.sv
rtl/rank_select25.sv
rtl/median7x7_top.sv
verification/clk_gen.sv
verification/median7x7_chk.sv
verification/median7x7_tb.sv

// File: Makefile
TOP := median7x7_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
